/* Makefile */
RTL = verilog/cachePkg.sv verilog/tagStore.sv verilog/dataStore.sv \
      verilog/cacheControl.sv verilog/cacheTop.sv

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall +incdir+include $(RTL) --top-module cacheTop

sim:
	verilator --binary --timing --timescale 1ns/100ps -f list.f --top-module cacheTb -o cacheTb
	@out=$$(./obj_dir/cacheTb); echo "$$out"; echo "$$out" | grep -qF '=== PASS ==='

clean:
	rm -rf obj_dir

/* include/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Address and data geometry
`define ADDR_WIDTH   16
`define DATA_WIDTH   16

// Address split, tag above index above offset
`define INDEX_WIDTH  4
`define OFFSET_WIDTH 2
`define TAG_WIDTH    10

// Cache organisation
`define NUM_LINES    16
`define LINE_WORDS   4

// Read/write codes on pRw and sysRw
`define RW_READ      1'b1
`define RW_WRITE     1'b0

`endif

/* list.f */
+incdir+include
verilog/cachePkg.sv
verilog/tagStore.sv
verilog/dataStore.sv
verilog/cacheControl.sv
verilog/cacheTop.sv
tb/cacheTb.sv

/* tb/cacheStimulus.txt */
# op addr wdata expected-read expected-miss, all in hex
# op 1 is a read and 0 a write; wdata and expected-read are 0000 where unused
1 0040 0000 5a1a 1
1 0041 0000 5a1b 0
1 0042 0000 5a18 0
1 0043 0000 5a19 0
0 0042 1234 0000 0
1 0042 0000 1234 0
1 0040 0000 5a1a 0
0 0105 beef 0000 0
1 0105 0000 beef 1
1 0104 0000 5b5e 0
1 0080 0000 5ada 1
1 0083 0000 5ad9 0
1 0042 0000 1234 1
1 0041 0000 5a1b 0
0 0081 7777 0000 0
1 0043 0000 5a19 0
1 0081 0000 7777 1
1 0082 0000 5ad8 0
1 ffff 0000 a5a5 1
1 fffc 0000 a5a6 0
1 fffd 0000 a5a7 0
0 fffe 0f0f 0000 0
1 fffe 0000 0f0f 0
1 7ffe 0000 25a4 1
1 fffe 0000 0f0f 1
1 fffc 0000 a5a6 0
0 1234 cafe 0000 0
0 1234 d00d 0000 0
1 1234 0000 d00d 1
1 1235 0000 486f 0
1 1236 0000 486c 0
1 1237 0000 486d 0
1 0040 0000 5a1a 1
1 0042 0000 1234 0
1 0100 0000 5b5a 1
1 0105 0000 beef 0

/* tb/cacheTb.sv */
`default_nettype none

`include "cache_macros.svh"

module cacheTb
	import cachePkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int clockPeriod      = 100;
	localparam int resetCycles      = 8;
	localparam int cyclesPerRequest = 12;

	logic   clock;
	logic   rstN;
	logic   pStrobe;
	logic   pRw;
	addrT   pAddr;
	dataT   pDataIn;
	dataT   pDataOut;
	logic   cReady;
	logic   sysStrobe;
	logic   sysRw;
	addrT   sysAddr;
	dataT   sysDataOut;
	dataT   sysData;
	offsetT sysWOffset;
	logic   readup;

	// System memory model
	dataT   memory [0:65535];
	logic   readStrobeSeen;
	integer seed;

	// Requests as read from the stimulus file
	logic   opQ [$];
	addrT   addrQ [$];
	dataT   dataQ [$];
	dataT   expReadQ [$];
	logic   expMissQ [$];
	logic   loaded;

	int     checkCount;
	int     errorCount;

	cacheTop i_dut (
		.clock      (clock),
		.rstN       (rstN),
		.pStrobe    (pStrobe),
		.pRw        (pRw),
		.pAddr      (pAddr),
		.pDataIn    (pDataIn),
		.pDataOut   (pDataOut),
		.cReady     (cReady),
		.sysStrobe  (sysStrobe),
		.sysRw      (sysRw),
		.sysAddr    (sysAddr),
		.sysDataOut (sysDataOut),
		.sysData    (sysData),
		.sysWOffset (sysWOffset),
		.readup     (readup)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#(clockPeriod / 2) clock = ~clock;
		end
	end

	task automatic checkEqual(input string what, input dataT actual, input dataT expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAILED at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// Word 0 sits on the bus during the latency, then words 0 to 3 follow
	task automatic returnLine(input addrT lineAddr);
		int latency;
		latency = 2 + int'($unsigned($random(seed)) % 4);
		@(posedge clock);
		#5;
		sysData    = memory[{lineAddr[`ADDR_WIDTH-1:`OFFSET_WIDTH], 2'b00}];
		sysWOffset = 2'd0;
		repeat (latency) begin
			@(posedge clock);
		end
		#5;
		for (int w = 0; w < `LINE_WORDS; w++) begin
			sysData    = memory[{lineAddr[`ADDR_WIDTH-1:`OFFSET_WIDTH], offsetT'(w)}];
			sysWOffset = offsetT'(w);
			readup     = (w == `LINE_WORDS - 1);
			@(posedge clock);
			#5;
		end
		readup = 1'b0;
	endtask

	initial begin
		for (int i = 0; i < 65536; i++) begin
			memory[i] = addrT'(i) ^ 16'h5a5a;
		end
		forever begin
			@(negedge clock);
			if (rstN && sysStrobe) begin
				if (sysRw == `RW_WRITE) begin
					memory[sysAddr] = sysDataOut;
				end else begin
					readStrobeSeen = 1'b1;
					returnLine(sysAddr);
				end
			end
		end
	end

	task automatic loadStimulus();
		int    fd;
		int    count;
		string line;
		logic  op;
		addrT  addr;
		dataT  data;
		dataT  expRead;
		logic  expMiss;
		fd = $fopen("tb/cacheStimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open tb/cacheStimulus.txt");
			errorCount++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
				count = $sscanf(line, "%h %h %h %h %h", op, addr, data, expRead, expMiss);
				if (count == 5) begin
					opQ.push_back(op);
					addrQ.push_back(addr);
					dataQ.push_back(data);
					expReadQ.push_back(expRead);
					expMissQ.push_back(expMiss);
				end else begin
					$display("malformed stimulus line: %s", line);
					errorCount++;
				end
			end
		end
		$fclose(fd);
		if (opQ.size() == 0) begin
			$display("no requests found in the stimulus file");
			errorCount++;
		end
	endtask

	task automatic runRequest(input int n);
		int    cycles;
		string label;
		label          = $sformatf("request %0d", n);
		pStrobe        = 1'b1;
		pRw            = opQ[n];
		pAddr          = addrQ[n];
		pDataIn        = dataQ[n];
		readStrobeSeen = 1'b0;
		cycles         = 0;
		do begin
			@(posedge clock);
			#5;
			pStrobe = 1'b0;
			cycles++;
		end while (!cReady);
		checkEqual({label, " line fetch"}, dataT'(readStrobeSeen), dataT'(expMissQ[n]));
		if (opQ[n] == `RW_READ) begin
			checkEqual({label, " read data"}, pDataOut, expReadQ[n]);
			if (!expMissQ[n]) begin
				checkEqual({label, " hit latency"}, dataT'(cycles), dataT'(1));
			end
		end else begin
			// Write-through is visible in the ready cycle
			checkEqual({label, " write latency"}, dataT'(cycles), dataT'(1));
			checkEqual({label, " sysStrobe"}, dataT'(sysStrobe), dataT'(1));
			checkEqual({label, " sysRw"}, dataT'(sysRw), dataT'(`RW_WRITE));
			checkEqual({label, " sysAddr"}, sysAddr, addrQ[n]);
			checkEqual({label, " sysDataOut"}, sysDataOut, dataQ[n]);
		end
	endtask

	initial begin
		int budget;
		wait (loaded);
		budget = opQ.size() * cyclesPerRequest + resetCycles;
		repeat (budget) begin
			@(posedge clock);
		end
		$display("timeout waiting for cReady");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		seed           = 32'h93b7;
		rstN           = 1'b0;
		pStrobe        = 1'b0;
		pRw            = `RW_READ;
		pAddr          = '0;
		pDataIn        = '0;
		sysData        = '0;
		sysWOffset     = '0;
		readup         = 1'b0;
		readStrobeSeen = 1'b0;
		checkCount     = 0;
		errorCount     = 0;
		loaded         = 1'b0;
		loadStimulus();
		loaded = 1'b1;
		repeat (resetCycles) begin
			@(posedge clock);
		end
		#5;
		rstN = 1'b1;
		checkEqual("cReady after reset", dataT'(cReady), dataT'(1));
		checkEqual("sysStrobe after reset", dataT'(sysStrobe), dataT'(0));
		for (int n = 0; n < opQ.size(); n++) begin
			// Reads chain in the ready cycle, writes get a free cycle on either side
			if (n > 0 && (opQ[n] == `RW_WRITE || opQ[n-1] == `RW_WRITE)) begin
				@(posedge clock);
				#5;
			end
			runRequest(n);
		end
		@(posedge clock);
		#5;
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/cacheControl.sv */
`default_nettype none

`include "cache_macros.svh"

module cacheControl
	import cachePkg::*;
(
	input  logic clock,
	input  logic rstN,

	// Processor side
	input  logic pStrobe,
	input  logic pRw,
	output logic cReady,

	// System side
	output logic sysStrobe,
	output logic sysRw,
	input  logic readup,

	// Tag store
	input  logic tagMatch,
	input  logic valid,
	output logic lineFlush,

	// Data store
	output logic doWrite,
	output logic dataFromSys
);

	cacheStateT state;
	cacheStateT nextState;

	logic hit;

	// State entered when a new request may start
	function automatic cacheStateT strobeTarget(input logic strobe, input logic rw);
		cacheStateT target;
		if (!strobe) begin
			target = stateIdle;
		end else if (rw == `RW_READ) begin
			target = stateRead;
		end else begin
			target = stateWrite;
		end
		return target;
	endfunction

	assign hit = tagMatch && valid;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= stateIdle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			stateIdle: begin
				nextState = strobeTarget(pStrobe, pRw);
			end
			stateRead: begin
				// Hits keep the read path open for back-to-back requests
				if (hit) begin
					nextState = strobeTarget(pStrobe, pRw);
				end else begin
					nextState = stateReadMiss;
				end
			end
			stateReadMiss: begin
				nextState = stateReadSys;
			end
			stateReadSys: begin
				// readup comes with the last word of the line
				if (readup) begin
					nextState = stateReadData;
				end
			end
			stateReadData: begin
				nextState = strobeTarget(pStrobe, pRw);
			end
			stateWrite: begin
				nextState = strobeTarget(pStrobe, pRw);
			end
			default: begin
				nextState = stateIdle;
			end
		endcase
	end

	always_comb begin
		cReady      = 1'b0;
		sysStrobe   = 1'b0;
		sysRw       = `RW_READ;
		doWrite     = 1'b0;
		dataFromSys = 1'b0;
		lineFlush   = 1'b0;
		case (state)
			stateIdle: begin
				cReady = 1'b1;
			end
			stateRead: begin
				cReady = hit;
			end
			stateReadMiss: begin
				// One-cycle line request, old line dropped
				sysStrobe = 1'b1;
				sysRw     = `RW_READ;
				lineFlush = 1'b1;
			end
			stateReadSys: begin
				// Word 0 is rewritten while the memory waits
				doWrite     = 1'b1;
				dataFromSys = 1'b1;
			end
			stateReadData: begin
				cReady = 1'b1;
			end
			stateWrite: begin
				// Write-through, cache updated only on a hit
				cReady    = 1'b1;
				sysStrobe = 1'b1;
				sysRw     = `RW_WRITE;
				doWrite   = hit;
			end
			default: begin
				cReady = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/cachePkg.sv */
`default_nettype none

`include "cache_macros.svh"

package cachePkg;

	// Word address and data word
	typedef logic [`ADDR_WIDTH-1:0]   addrT;
	typedef logic [`DATA_WIDTH-1:0]   dataT;

	// Fields of the split address
	typedef logic [`TAG_WIDTH-1:0]    tagT;
	typedef logic [`INDEX_WIDTH-1:0]  indexT;
	typedef logic [`OFFSET_WIDTH-1:0] offsetT;

	// Controller states
	typedef enum logic [2:0] {
		stateIdle     = 3'd0,
		stateRead     = 3'd1,
		stateReadMiss = 3'd2,
		stateReadSys  = 3'd3,
		stateReadData = 3'd4,
		stateWrite    = 3'd5
	} cacheStateT;

endpackage

`default_nettype wire

/* verilog/cacheTop.sv */
`default_nettype none

`include "cache_macros.svh"

module cacheTop
	import cachePkg::*;
(
	input  logic   clock,
	input  logic   rstN,

	// Processor port
	input  logic   pStrobe,
	input  logic   pRw,
	input  addrT   pAddr,
	input  dataT   pDataIn,
	output dataT   pDataOut,
	output logic   cReady,

	// System memory port
	output logic   sysStrobe,
	output logic   sysRw,
	output addrT   sysAddr,
	output dataT   sysDataOut,
	input  dataT   sysData,
	input  offsetT sysWOffset,
	input  logic   readup
);

	tagT    tag;
	indexT  index;
	offsetT offset;

	logic tagMatch;
	logic valid;
	logic doWrite;
	logic dataFromSys;
	logic lineFlush;

	// Address split, tag on top
	assign tag    = pAddr[`ADDR_WIDTH-1 -: `TAG_WIDTH];
	assign index  = pAddr[`OFFSET_WIDTH +: `INDEX_WIDTH];
	assign offset = pAddr[`OFFSET_WIDTH-1:0];

	// Misses and write-through use the processor address and data as is
	assign sysAddr    = pAddr;
	assign sysDataOut = pDataIn;

	cacheControl i_control (
		.clock       (clock),
		.rstN        (rstN),
		.pStrobe     (pStrobe),
		.pRw         (pRw),
		.cReady      (cReady),
		.sysStrobe   (sysStrobe),
		.sysRw       (sysRw),
		.readup      (readup),
		.tagMatch    (tagMatch),
		.valid       (valid),
		.lineFlush   (lineFlush),
		.doWrite     (doWrite),
		.dataFromSys (dataFromSys)
	);

	tagStore i_tagStore (
		.clock     (clock),
		.rstN      (rstN),
		.index     (index),
		.tag       (tag),
		.lineFlush (lineFlush),
		.readup    (readup),
		.tagMatch  (tagMatch),
		.valid     (valid)
	);

	dataStore i_dataStore (
		.clock       (clock),
		.index       (index),
		.pOffset     (offset),
		.sysWOffset  (sysWOffset),
		.pDataIn     (pDataIn),
		.sysData     (sysData),
		.doWrite     (doWrite),
		.dataFromSys (dataFromSys),
		.readData    (pDataOut)
	);

endmodule

`default_nettype wire

/* verilog/dataStore.sv */
`default_nettype none

module dataStore
	import cachePkg::*;
(
	input  logic   clock,

	// Line and word select
	input  indexT  index,
	input  offsetT pOffset,
	input  offsetT sysWOffset,

	// Write data sources
	input  dataT   pDataIn,
	input  dataT   sysData,

	// Write control
	input  logic   doWrite,
	input  logic   dataFromSys,

	output dataT   readData
);

	localparam int numWords = 2 ** ($bits(indexT) + $bits(offsetT));

	dataT   mem [0:numWords-1];
	offsetT wOffset;
	dataT   wData;

	// Fill words come from the system, write hits from the processor
	always_comb begin
		if (dataFromSys) begin
			wOffset = sysWOffset;
			wData   = sysData;
		end else begin
			wOffset = pOffset;
			wData   = pDataIn;
		end
	end

	always_ff @(posedge clock) begin
		if (doWrite) begin
			mem[{index, wOffset}] <= wData;
		end
	end

	// Asynchronous read so a hit returns in the same cycle as cReady
	assign readData = mem[{index, pOffset}];

endmodule

`default_nettype wire

/* verilog/tagStore.sv */
`default_nettype none

module tagStore
	import cachePkg::*;
(
	input  logic  clock,
	input  logic  rstN,

	input  indexT index,
	input  tagT   tag,

	// Fill control from the controller and the system
	input  logic  lineFlush,
	input  logic  readup,

	output logic  tagMatch,
	output logic  valid
);

	localparam int numLines = 2 ** $bits(indexT);

	tagT  tags [0:numLines-1];
	logic validBits [0:numLines-1];

	// New tag is loaded when the line is flushed for a fill
	always_ff @(posedge clock) begin
		if (lineFlush) begin
			tags[index] <= tag;
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int i = 0; i < numLines; i++) begin
				validBits[i] <= 1'b0;
			end
		end else if (lineFlush) begin
			validBits[index] <= 1'b0;
		end else if (readup) begin
			// Line complete once the last word arrives
			validBits[index] <= 1'b1;
		end
	end

	always_comb begin
		tagMatch = (tags[index] == tag);
		valid    = validBits[index];
	end

endmodule

`default_nettype wire
